//--- bench/tb_vcp.sv
`timescale 1ns/1ps

module tb_vcp import vcp_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    elem_t       xreg_data;
    logic        scalar_valid;
    logic        scalar_ready;
    vreg_addr_t  scalar_rd;
    elem_t       scalar_data;
    logic        store_valid;
    logic        store_ready;
    elem_t       store_addr;
    vreg_t       store_data;

    vreg_t       shadow [NUM_VREGS];  // Expected register file contents
    int          cur_vl;
    integer      seed = 32'h8b3e3170;
    int          wait_limit = 64;     // Cycles allowed per wait
    int          error_count;
    int          check_count;
    int          test_count;

    always #10 clk = ~clk;

    vcp_top u_dut (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr(instr), .xreg_data(xreg_data),
        .scalar_valid(scalar_valid), .scalar_ready(scalar_ready),
        .scalar_rd(scalar_rd), .scalar_data(scalar_data),
        .store_valid(store_valid), .store_ready(store_ready),
        .store_addr(store_addr), .store_data(store_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_vreg(input string name, input vreg_t got, input vreg_t exp);
        logic same;
        same = 1'b1;
        for (int i = 0; i < VLEN_ELEMS; i++) begin
            if (got[i] !== exp[i]) same = 1'b0;
        end
        check_count++;
        if (!same) begin
            error_count++;
            $display("Mismatch %s: got %h_%h_%h_%h expected %h_%h_%h_%h", name,
                     got[3], got[2], got[1], got[0], exp[3], exp[2], exp[1], exp[0]);
        end
    endtask

    task automatic check_elem(input string name, input elem_t got, input elem_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input vreg_addr_t got, input vreg_addr_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error: %s", msg);
    endtask

    task automatic finish_test(input string name, input int err0);
        test_count++;
        if (error_count == err0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, error_count - err0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Encoding and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_vop(input v_op_e op, input opnd_kind_e kind,
            input vreg_addr_t vd, input vreg_addr_t vs2, input logic [4:0] src);
        logic [5:0] funct6;
        case (op)
            V_SUB:      funct6 = F6_VSUB;
            V_AND:      funct6 = F6_VAND;
            V_OR:       funct6 = F6_VOR;
            V_XOR:      funct6 = F6_VXOR;
            V_MUL:      funct6 = F6_VMUL;
            V_SLIDE1UP: funct6 = F6_VSLIDE1UP;
            V_REDSUM:   funct6 = F6_VREDSUM;
            V_REDMAXU:  funct6 = F6_VREDMAXU;
            default:    funct6 = F6_VADD;
        endcase
        return {funct6, 1'b1, vs2, src, kind, vd, OPC_OP_V};  // Unmasked
    endfunction

    function automatic logic [31:0] enc_vse(input vreg_addr_t vs3);
        return {3'b000, 1'b0, 2'b00, 1'b1, 5'b00000, 5'd10, F3_VSE32, vs3, OPC_STORE_FP};
    endfunction

    function automatic opnd_kind_e kind_for(input v_op_e op, input int form);
        opnd_kind_e k;
        case (form)
            0:       k = OPIVV;
            1:       k = OPIVX;
            default: k = OPIVI;
        endcase
        if (op == V_MUL && form == 0) k = OPMVV;  // vmul lives in the OPM space
        if (op == V_MUL && form == 1) k = OPMVX;
        return k;
    endfunction

    // Element result of vs2 op A
    function automatic elem_t lane_model(input v_op_e op, input elem_t b, input elem_t a);
        case (op)
            V_ADD:   return b + a;
            V_SUB:   return b - a;
            V_AND:   return b & a;
            V_OR:    return b | a;
            V_XOR:   return b ^ a;
            V_MUL:   return b * a;  // Low 32 bits
            default: return b;
        endcase
    endfunction

    function automatic elem_t rand_elem();
        return $random(seed);
    endfunction

    task automatic fill_random(output vreg_t v);
        for (int i = 0; i < VLEN_ELEMS; i++) v[i] = rand_elem();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_instr(input logic [31:0] word, input elem_t xval);
        int cycles;
        cycles      = 0;
        instr_valid = 1'b1;
        instr       = word;
        xreg_data   = xval;
        while (!instr_ready && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        if (!instr_ready) report_error("instr_ready stayed low, instruction not accepted");
        next_cycle();  // Transfer edge
        instr_valid = 1'b0;
    endtask

    // Issue a vector op and update the expected copy of vd
    task automatic run_vop(input v_op_e op, input opnd_kind_e kind, input vreg_addr_t vd,
                           input vreg_addr_t vs2, input logic [4:0] src, input elem_t xval);
        vreg_t old_a;
        vreg_t old_b;
        elem_t a;
        old_a = shadow[src];
        old_b = shadow[vs2];
        send_instr(enc_vop(op, kind, vd, vs2, src), xval);
        for (int i = 0; i < cur_vl; i++) begin
            case (kind)
                OPIVX, OPMVX: a = xval;
                OPIVI:        a = {{(ELEM_W-5){src[4]}}, src};
                default:      a = old_a[i];
            endcase
            if (op != V_SLIDE1UP) shadow[vd][i] = lane_model(op, old_b[i], a);
            else if (i == 0)      shadow[vd][i] = xval;
            else                  shadow[vd][i] = old_b[i-1];
        end
    endtask

    task automatic set_vl(input elem_t avl);
        send_instr({1'b1, 6'b000000, 5'd11, 5'd10, OPCFG, 5'd0, OPC_OP_V}, avl);
        cur_vl = (avl > VLEN_ELEMS) ? VLEN_ELEMS : int'(avl);
    endtask

    // Last slide lands in element 0, so insert from the top down
    task automatic load_vec(input vreg_addr_t vd, input vreg_t val);
        for (int k = VLEN_ELEMS - 1; k >= 0; k--) begin
            run_vop(V_SLIDE1UP, OPMVX, vd, vd, 5'd0, val[k]);
        end
    endtask

    task automatic take_store(input int stall, output vreg_t data, output elem_t addr);
        int cycles;
        cycles = 0;
        while (!store_valid && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        if (!store_valid) report_error("store_valid never rose after vse");
        data = store_data;
        addr = store_addr;
        for (int k = 0; k < stall; k++) begin
            next_cycle();
            if (!store_valid) report_error("store_valid dropped while store_ready was low");
            if (instr_ready) report_error("instr_ready rose while a store was pending");
            check_vreg("store_data", store_data, data);
            check_elem("store_addr", store_addr, addr);
        end
        store_ready = 1'b1;
        next_cycle();
        store_ready = 1'b0;
    endtask

    task automatic take_scalar(input int stall, output vreg_addr_t rd, output elem_t data);
        int cycles;
        cycles = 0;
        while (!scalar_valid && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        if (!scalar_valid) report_error("scalar_valid never rose after reduction");
        rd   = scalar_rd;
        data = scalar_data;
        for (int k = 0; k < stall; k++) begin
            next_cycle();
            if (!scalar_valid) report_error("scalar_valid dropped while scalar_ready was low");
            if (instr_ready) report_error("instr_ready rose while a scalar result was pending");
            check_addr("scalar_rd", scalar_rd, rd);
            check_elem("scalar_data", scalar_data, data);
        end
        scalar_ready = 1'b1;
        next_cycle();
        scalar_ready = 1'b0;
    endtask

    task automatic read_vec(input vreg_addr_t vs3, input int stall, output vreg_t data);
        elem_t addr;
        elem_t got_addr;
        addr = rand_elem();
        send_instr(enc_vse(vs3), addr);
        take_store(stall, data, got_addr);
        check_elem("store_addr", got_addr, addr);  // Address is rs1
    endtask

    task automatic verify_reg(input vreg_addr_t r, input int stall);
        vreg_t data;
        read_vec(r, stall, data);
        check_vreg($sformatf("v%0d", r), data, shadow[r]);
    endtask

    task automatic run_red(input v_op_e op, input vreg_addr_t rd, input vreg_addr_t vs2,
                           input vreg_addr_t vs1, input int stall);
        elem_t      exp;
        elem_t      got;
        vreg_addr_t got_rd;
        exp = shadow[vs1][0];
        for (int i = 0; i < cur_vl; i++) begin
            if (op == V_REDMAXU) exp = (shadow[vs2][i] > exp) ? shadow[vs2][i] : exp;
            else exp = exp + shadow[vs2][i];
        end
        send_instr(enc_vop(op, OPMVV, rd, vs2, vs1), '0);
        take_scalar(stall, got_rd, got);
        check_addr("scalar_rd", got_rd, rd);
        check_elem("scalar_data", got, exp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int err0;
        err0 = error_count;
        if (instr_ready !== 1'b1) report_error("instr_ready not high after reset");
        if (scalar_valid !== 1'b0) report_error("scalar_valid not low after reset");
        if (store_valid !== 1'b0) report_error("store_valid not low after reset");
        verify_reg(5'd0, 0);  // Cleared by reset
        finish_test("reset", err0);
    endtask

    task automatic test_elementwise();
        v_op_e      ops [6] = '{V_ADD, V_SUB, V_AND, V_OR, V_XOR, V_MUL};
        vreg_t      v1;
        vreg_t      v2;
        logic [4:0] imm;
        int         err0;
        err0 = error_count;
        fill_random(v1);
        fill_random(v2);
        load_vec(5'd1, v1);
        load_vec(5'd2, v2);
        foreach (ops[k]) begin
            for (int form = 0; form < 3; form++) begin
                imm = 5'(rand_elem());
                run_vop(ops[k], kind_for(ops[k], form), 5'd8, 5'd2,
                        (form == 2) ? imm : 5'd1, rand_elem());
                verify_reg(5'd8, 0);
            end
        end
        finish_test("elementwise", err0);
    endtask

    task automatic test_slide();
        vreg_t v;
        vreg_t data;
        int    err0;
        err0 = error_count;
        fill_random(v);
        load_vec(5'd9, v);
        read_vec(5'd9, 0, data);
        check_vreg("v9", data, v);  // Insertion order kept
        finish_test("slide", err0);
    endtask

    task automatic test_vl_tail();
        vreg_t v3;
        vreg_t v4;
        vreg_t v6;
        vreg_t exp;
        vreg_t data;
        int    err0;
        err0 = error_count;
        fill_random(v3);
        fill_random(v4);
        fill_random(v6);
        load_vec(5'd3, v3);
        load_vec(5'd4, v4);
        load_vec(5'd6, v6);
        set_vl(2);
        run_vop(V_ADD, OPIVV, 5'd6, 5'd4, 5'd3, '0);
        for (int i = 0; i < VLEN_ELEMS; i++) begin
            exp[i] = (i < 2) ? v4[i] + v3[i] : v6[i];
        end
        read_vec(5'd6, 0, data);
        check_vreg("v6", data, exp);
        set_vl(9);  // Clamps to 4
        run_vop(V_XOR, OPIVX, 5'd6, 5'd4, 5'd0, rand_elem());
        verify_reg(5'd6, 0);
        finish_test("vl_tail", err0);
    endtask

    task automatic test_reductions();
        vreg_t v;
        int    err0;
        err0 = error_count;
        fill_random(v);
        load_vec(5'd10, v);
        fill_random(v);
        load_vec(5'd11, v);
        run_red(V_REDSUM, 5'd17, 5'd11, 5'd10, 0);
        run_red(V_REDMAXU, 5'd18, 5'd11, 5'd10, 0);
        set_vl(0);
        run_red(V_REDSUM, 5'd19, 5'd11, 5'd10, 0);
        run_red(V_REDMAXU, 5'd20, 5'd11, 5'd10, 0);
        set_vl(4);
        finish_test("reductions", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        err0 = error_count;
        run_red(V_REDSUM, 5'd21, 5'd11, 5'd10, 3 + ($random(seed) & 7));
        run_vop(V_SUB, OPIVV, 5'd12, 5'd11, 5'd10, '0);
        verify_reg(5'd12, 3 + ($random(seed) & 7));
        run_vop(V_MUL, OPMVX, 5'd13, 5'd12, 5'd0, rand_elem());  // Follow-up after stall
        verify_reg(5'd13, 0);
        finish_test("backpressure", err0);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        xreg_data    = '0;
        scalar_ready = 1'b0;
        store_ready  = 1'b0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        cur_vl       = VLEN_ELEMS;
        for (int r = 0; r < NUM_VREGS; r++) begin
            for (int e = 0; e < VLEN_ELEMS; e++) shadow[r][e] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_elementwise();
        test_slide();
        test_vl_tail();
        test_reductions();
        test_backpressure();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/v_issue.sv
`timescale 1ns/1ps

module v_issue import vcp_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    output logic        instr_ready,
    input  logic [31:0] instr,
    input  elem_t       xreg_data,
    output vreg_addr_t  rd_addr_1,
    output vreg_addr_t  rd_addr_2,
    output vreg_addr_t  rd_addr_3,
    input  vreg_t       rd_data_1,
    input  vreg_t       rd_data_2,
    input  vreg_t       rd_data_3,
    input  logic        retire,
    vcp_exec_if.issue   exec
);

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT_RETIRE} issue_state_e;

    issue_state_e     state;
    logic [31:0]      instr_q;
    elem_t            xreg_q;
    logic [VL_W-1:0]  vl;
    v_op_e            dec_op;
    result_dest_e     dec_dest;
    opnd_kind_e       kind;
    logic [5:0]       funct6;
    elem_t            imm_sext;
    vreg_t            opnd_a_sel;

    assign instr_ready = (state == IDLE);

    assign kind      = opnd_kind_e'(instr_q[14:12]);
    assign funct6    = instr_q[31:26];
    assign imm_sext  = {{(ELEM_W-5){instr_q[19]}}, instr_q[19:15]};
    assign rd_addr_1 = instr_q[19:15];
    assign rd_addr_2 = instr_q[24:20];
    assign rd_addr_3 = instr_q[11:7];

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        dec_op = V_NOP;  // Unknown encodings drop out here
        if (instr_q[6:0] == OPC_STORE_FP && instr_q[14:12] == F3_VSE32) begin
            dec_op = V_STORE;
        end else if (instr_q[6:0] == OPC_OP_V) begin
            case (kind)
                OPIVV, OPIVX, OPIVI: begin
                    case (funct6)
                        F6_VADD: dec_op = V_ADD;
                        F6_VSUB: dec_op = V_SUB;
                        F6_VAND: dec_op = V_AND;
                        F6_VOR:  dec_op = V_OR;
                        F6_VXOR: dec_op = V_XOR;
                        F6_VMUL: if (kind == OPIVI) dec_op = V_MUL;
                        default: dec_op = V_NOP;
                    endcase
                end
                OPMVV, OPMVX: begin
                    case (funct6)
                        F6_VMUL:      dec_op = V_MUL;
                        F6_VSLIDE1UP: if (kind == OPMVX) dec_op = V_SLIDE1UP;
                        F6_VREDSUM:   if (kind == OPMVV) dec_op = V_REDSUM;
                        F6_VREDMAXU:  if (kind == OPMVV) dec_op = V_REDMAXU;
                        default:      dec_op = V_NOP;
                    endcase
                end
                OPCFG:   if (instr_q[31]) dec_op = V_SETVL;  // vsetvl only
                default: dec_op = V_NOP;
            endcase
        end

        case (dec_op)
            V_REDSUM, V_REDMAXU: dec_dest = DEST_SCALAR;
            V_STORE:             dec_dest = DEST_STORE;
            V_SETVL, V_NOP:      dec_dest = DEST_NONE;
            default:             dec_dest = DEST_VREG;
        endcase
    end

    // Operand A, splat of scalar or immediate
    always_comb begin
        for (int i = 0; i < VLEN_ELEMS; i++) begin
            case (kind)
                OPIVX, OPMVX: opnd_a_sel[i] = xreg_q;
                OPIVI:        opnd_a_sel[i] = imm_sext;
                default:      opnd_a_sel[i] = rd_data_1[i];
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            exec.valid <= 1'b0;
            vl         <= VL_W'(VLEN_ELEMS);
        end else begin
            exec.valid <= (state == ISSUE);
            case (state)
                IDLE:        if (instr_valid) state <= ISSUE;
                ISSUE: begin
                    state <= WAIT_RETIRE;
                    if (dec_op == V_SETVL) begin
                        // Clamp to VLMAX
                        vl <= (xreg_q > ELEM_W'(VLEN_ELEMS)) ? VL_W'(VLEN_ELEMS)
                                                              : VL_W'(xreg_q);
                    end
                end
                WAIT_RETIRE: if (retire) state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            instr_q <= instr;
            xreg_q  <= xreg_data;
        end
        if (state == ISSUE) begin
            exec.op     <= dec_op;
            exec.dest   <= dec_dest;
            exec.vd     <= instr_q[11:7];
            exec.rd     <= instr_q[11:7];  // Scalar result index
            exec.opnd_a <= opnd_a_sel;
            exec.opnd_b <= rd_data_2;
            exec.old_vd <= rd_data_3;
            exec.vl     <= vl;
            exec.scalar <= xreg_q;
        end
    end

endmodule

//--- hw/v_lanes.sv
`timescale 1ns/1ps

module v_lanes import vcp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    vcp_exec_if.exec   exec,
    output logic       lane_valid,
    output vreg_t      lane_result
);

    vreg_t alu_res;
    vreg_t slide_res;

    // Element 0 takes rs1, the rest move up by one
    always_comb begin
        slide_res[0] = exec.opnd_a[0];
        for (int i = 1; i < VLEN_ELEMS; i++) begin
            slide_res[i] = exec.opnd_b[i-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-lane ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < VLEN_ELEMS; i++) begin
            case (exec.op)
                V_ADD:      alu_res[i] = exec.opnd_b[i] + exec.opnd_a[i];
                V_SUB:      alu_res[i] = exec.opnd_b[i] - exec.opnd_a[i];  // vs2 - A
                V_AND:      alu_res[i] = exec.opnd_b[i] & exec.opnd_a[i];
                V_OR:       alu_res[i] = exec.opnd_b[i] | exec.opnd_a[i];
                V_XOR:      alu_res[i] = exec.opnd_b[i] ^ exec.opnd_a[i];
                V_MUL:      alu_res[i] = exec.opnd_b[i] * exec.opnd_a[i];  // Low half
                V_SLIDE1UP: alu_res[i] = slide_res[i];
                default:    alu_res[i] = exec.opnd_b[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= exec.valid && (exec.dest == DEST_VREG);
        end
    end

    always_ff @(posedge clk) begin
        if (exec.valid) begin
            lane_result <= alu_res;
        end
    end

endmodule

//--- hw/v_red.sv
`timescale 1ns/1ps

module v_red import vcp_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    vcp_exec_if.exec   exec,
    output logic       red_done,
    output elem_t      red_result
);

    logic             busy;
    logic [VL_W-1:0]  idx;       // Next vs2 element
    elem_t            elem;
    elem_t            red_step;

    assign elem     = exec.opnd_b[idx[1:0]];
    assign red_step = (exec.op == V_REDMAXU) ? ((elem > red_result) ? elem : red_result)
                                             : red_result + elem;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            idx      <= '0;
            red_done <= 1'b0;
        end else begin
            red_done <= 1'b0;
            if (exec.valid && exec.dest == DEST_SCALAR) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                if (idx == exec.vl) begin  // All active elements folded in
                    busy     <= 1'b0;
                    red_done <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // Accumulator seeded from vs1[0]
    always_ff @(posedge clk) begin
        if (exec.valid) begin
            red_result <= exec.opnd_a[0];
        end else if (busy && idx != exec.vl) begin
            red_result <= red_step;
        end
    end

endmodule

//--- hw/v_regfile.sv
`timescale 1ns/1ps

module v_regfile import vcp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  vreg_addr_t             rd_addr_1,
    input  vreg_addr_t             rd_addr_2,
    input  vreg_addr_t             rd_addr_3,
    output vreg_t                  rd_data_1,
    output vreg_t                  rd_data_2,
    output vreg_t                  rd_data_3,
    input  logic                   wr_en,
    input  vreg_addr_t             wr_addr,
    input  logic [VLEN_ELEMS-1:0]  wr_elem_en,
    input  vreg_t                  wr_data
);

    vreg_t regs [NUM_VREGS];

    // Element-granular write keeps the tail intact
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                for (int e = 0; e < VLEN_ELEMS; e++) begin
                    regs[r][e] <= '0;
                end
            end
        end else if (wr_en) begin
            for (int e = 0; e < VLEN_ELEMS; e++) begin
                if (wr_elem_en[e]) begin
                    regs[wr_addr][e] <= wr_data[e];
                end
            end
        end
    end

    // Asynchronous reads
    assign rd_data_1 = regs[rd_addr_1];  // vs1
    assign rd_data_2 = regs[rd_addr_2];  // vs2
    assign rd_data_3 = regs[rd_addr_3];  // vd / vs3

endmodule

//--- hw/v_writeback.sv
`timescale 1ns/1ps

module v_writeback import vcp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    vcp_exec_if.commit             exec,
    input  logic                   lane_valid,
    input  vreg_t                  lane_result,
    input  logic                   red_done,
    input  elem_t                  red_result,
    output logic                   wr_en,
    output vreg_addr_t             wr_addr,
    output logic [VLEN_ELEMS-1:0]  wr_elem_en,
    output vreg_t                  wr_data,
    output logic                   retire,
    output logic                   scalar_valid,
    input  logic                   scalar_ready,
    output vreg_addr_t             scalar_rd,
    output elem_t                  scalar_data,
    output logic                   store_valid,
    input  logic                   store_ready,
    output elem_t                  store_addr,
    output vreg_t                  store_data
);

    // Body elements from the lanes, tail elements not enabled
    always_comb begin
        for (int i = 0; i < VLEN_ELEMS; i++) begin
            wr_elem_en[i] = (i < exec.vl);
            wr_data[i]    = lane_result[i];
        end
    end

    assign wr_en   = lane_valid;
    assign wr_addr = exec.vd;

    assign retire = lane_valid
                  | (exec.valid && exec.dest == DEST_NONE)  // vsetvl, dropped instr
                  | (scalar_valid && scalar_ready)
                  | (store_valid && store_ready);

    ////////////////////////////////////////////////////////////////////////////
    // Scalar and store output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            scalar_valid <= 1'b0;
            store_valid  <= 1'b0;
        end else begin
            if (red_done) scalar_valid <= 1'b1;
            else if (scalar_ready) scalar_valid <= 1'b0;
            if (exec.valid && exec.dest == DEST_STORE) store_valid <= 1'b1;
            else if (store_ready) store_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (red_done) begin
            scalar_rd   <= exec.rd;
            scalar_data <= red_result;
        end
        if (exec.valid && exec.dest == DEST_STORE) begin
            store_addr <= exec.scalar;  // rs1
            store_data <= exec.old_vd;  // vs3
        end
    end

endmodule

//--- hw/vcp_exec_if.sv
`timescale 1ns/1ps

interface vcp_exec_if import vcp_pkg::*; ();

    logic             valid;    // One-cycle issue pulse
    v_op_e            op;
    result_dest_e     dest;
    vreg_addr_t       vd;
    vreg_addr_t       rd;
    vreg_t            opnd_a;   // vs1, rs1 or imm, splatted
    vreg_t            opnd_b;   // vs2
    vreg_t            old_vd;   // Tail source and store data
    logic [VL_W-1:0]  vl;
    elem_t            scalar;   // rs1, store address

    modport issue  (output valid, op, dest, vd, rd, opnd_a, opnd_b, old_vd, vl, scalar);

    // Lanes and reduction unit
    modport exec   (input valid, op, dest, opnd_a, opnd_b, vl);

    modport commit (input valid, dest, vd, rd, old_vd, vl, scalar);

endinterface

//--- hw/vcp_pkg.sv
package vcp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int VLEN_ELEMS = 4;                   // Elements per register
    localparam int VREG_W     = 128;                 // VLEN
    localparam int ELEM_W     = VREG_W / VLEN_ELEMS; // SEW fixed at 32
    localparam int NUM_VREGS  = 32;
    localparam int VL_W       = 3;                   // Holds 0 to 4

    // Major opcodes
    localparam logic [6:0] OPC_OP_V     = 7'b1010111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

    localparam logic [2:0] F3_VSE32 = 3'b110;        // Width field of vse32

    // funct6 codes
    localparam logic [5:0] F6_VADD      = 6'b000000;
    localparam logic [5:0] F6_VSUB      = 6'b000010;
    localparam logic [5:0] F6_VAND      = 6'b001001;
    localparam logic [5:0] F6_VOR       = 6'b001010;
    localparam logic [5:0] F6_VXOR      = 6'b001011;
    localparam logic [5:0] F6_VMUL      = 6'b100101; // Also taken in OPIVI form
    localparam logic [5:0] F6_VSLIDE1UP = 6'b001110;
    localparam logic [5:0] F6_VREDSUM   = 6'b000000;
    localparam logic [5:0] F6_VREDMAXU  = 6'b000110;

    typedef enum logic [3:0] {
        V_ADD,
        V_SUB,
        V_AND,
        V_OR,
        V_XOR,
        V_MUL,
        V_SLIDE1UP,
        V_REDSUM,
        V_REDMAXU,
        V_SETVL,
        V_STORE,
        V_NOP
    } v_op_e;

    // funct3 operand form
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPMVX = 3'b110,
        OPCFG = 3'b111
    } opnd_kind_e;

    typedef enum logic [1:0] {
        DEST_VREG,
        DEST_SCALAR,
        DEST_STORE,
        DEST_NONE
    } result_dest_e;

    typedef logic [ELEM_W-1:0]             elem_t;
    typedef elem_t                         vreg_t [VLEN_ELEMS];
    typedef logic [$clog2(NUM_VREGS)-1:0]  vreg_addr_t;

endpackage

//--- hw/vcp_top.sv
`timescale 1ns/1ps

module vcp_top import vcp_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    output logic        instr_ready,
    input  logic [31:0] instr,
    input  elem_t       xreg_data,
    output logic        scalar_valid,
    input  logic        scalar_ready,
    output vreg_addr_t  scalar_rd,
    output elem_t       scalar_data,
    output logic        store_valid,
    input  logic        store_ready,
    output elem_t       store_addr,
    output vreg_t       store_data
);

    vreg_addr_t              rd_addr_1, rd_addr_2, rd_addr_3;
    vreg_t                   rd_data_1, rd_data_2, rd_data_3;
    logic                    wr_en;
    vreg_addr_t              wr_addr;
    logic [VLEN_ELEMS-1:0]   wr_elem_en;
    vreg_t                   wr_data;
    logic                    retire;
    logic                    lane_valid;
    vreg_t                   lane_result;
    logic                    red_done;
    elem_t                   red_result;

    vcp_exec_if exec_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    v_issue u_issue (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr(instr), .xreg_data(xreg_data),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2), .rd_addr_3(rd_addr_3),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2), .rd_data_3(rd_data_3),
        .retire(retire), .exec(exec_bus.issue)
    );

    v_regfile u_regfile (
        .clk(clk), .reset(reset),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2), .rd_addr_3(rd_addr_3),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2), .rd_data_3(rd_data_3),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_elem_en(wr_elem_en), .wr_data(wr_data)
    );

    // Execution units
    v_lanes u_lanes (
        .clk(clk), .reset(reset), .exec(exec_bus.exec),
        .lane_valid(lane_valid), .lane_result(lane_result)
    );

    v_red u_red (
        .clk(clk), .reset(reset), .exec(exec_bus.exec),
        .red_done(red_done), .red_result(red_result)
    );

    v_writeback u_writeback (
        .clk(clk), .reset(reset), .exec(exec_bus.commit),
        .lane_valid(lane_valid), .lane_result(lane_result),
        .red_done(red_done), .red_result(red_result),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_elem_en(wr_elem_en), .wr_data(wr_data),
        .retire(retire),
        .scalar_valid(scalar_valid), .scalar_ready(scalar_ready),
        .scalar_rd(scalar_rd), .scalar_data(scalar_data),
        .store_valid(store_valid), .store_ready(store_ready),
        .store_addr(store_addr), .store_data(store_data)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_vcp -f vlog.f -o tb_vcp
./obj_dir/tb_vcp | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- vlog.f
hw/vcp_pkg.sv
hw/vcp_exec_if.sv
hw/v_regfile.sv
hw/v_issue.sv
hw/v_lanes.sv
hw/v_red.sv
hw/v_writeback.sv
hw/vcp_top.sv
bench/tb_vcp.sv
